// File: Makefile
TOP := gfx_striped_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): files.f $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: files.f
+incdir+rtl
rtl/gfx_draw_pkg.sv
rtl/vga_pkg.sv
rtl/shape_regs.sv
rtl/shape_drawer.sv
rtl/stripe_fb.sv
rtl/vga_timing.sv
rtl/fb_scanout.sv
rtl/gfx_striped_top.sv
tb/gfx_striped_chk.sv
tb/gfx_striped_tb.sv

// File: rtl/fb_scanout.sv
// scanout with group fetch, pixel shift out and two stage sync alignment
`timescale 1ns/1ns
`include "gfx_params.svh"

module fb_scanout #(
  parameter int NUM_S = `FB_NUM_S
) (
  input  logic                         pixel_clk,
  input  logic                         rst_n,
  input  logic [`X_W-1:0]              x,
  input  logic [`Y_W-1:0]              y,
  input  logic                         active,
  input  logic                         hsync,
  input  logic                         vsync,
  input  logic [NUM_S*`PIX_W-1:0]      rd_data,
  output logic                         rd_en,
  output logic [$clog2(`FB_WORDS)-1:0] rd_addr,
  output logic [`COLOR_W-1:0]          vga_red,
  output logic [`COLOR_W-1:0]          vga_grn,
  output logic [`COLOR_W-1:0]          vga_blu,
  output logic                         vga_hsync,
  output logic                         vga_vsync
);

  localparam int ADDR_W    = $clog2(`FB_WORDS);
  localparam int ROW_WORDS = `H_ACTIVE / NUM_S;

  logic                      act_q;
  logic                      hs_q;
  logic                      vs_q;
  logic                      load_q;
  logic [NUM_S*`PIX_W-1:0]   shift_q;
  logic [`PIX_W-1:0]         pix;

  // one fetch at the first pixel of each group
  assign rd_en   = active && (32'(x) % NUM_S == 0);
  assign rd_addr = ADDR_W'(32'(y) * ROW_WORDS + 32'(x) / NUM_S);

  // bank 0 holds the leftmost pixel of the group
  assign pix = load_q ? rd_data[`PIX_W-1:0] : shift_q[`PIX_W-1:0];

  // stage 1, matches the read latency
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      act_q  <= 1'b0;
      hs_q   <= 1'b1;
      vs_q   <= 1'b1;
      load_q <= 1'b0;
    end else begin
      act_q  <= active;
      hs_q   <= hsync;
      vs_q   <= vsync;
      load_q <= rd_en;
    end
  end

  always_ff @(posedge pixel_clk) begin
    shift_q <= (load_q ? rd_data : shift_q) >> `PIX_W;
  end

  // stage 2, registered outputs with blanking
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
    end else begin
      vga_red   <= act_q ? pix[3*`COLOR_W-1:2*`COLOR_W] : '0;
      vga_grn   <= act_q ? pix[2*`COLOR_W-1:`COLOR_W] : '0;
      vga_blu   <= act_q ? pix[`COLOR_W-1:0] : '0;
      vga_hsync <= hs_q;
      vga_vsync <= vs_q;
    end
  end

endmodule

// File: rtl/gfx_draw_pkg.sv
// shape opcode, register address and drawer state enums
package gfx_draw_pkg;

  // shape command opcodes
  typedef enum logic [1:0] {
    op_clear = 2'd0,
    op_fill  = 2'd1,
    op_frame = 2'd2
  } shape_op_e;

  // register map of the command block
  typedef enum logic [2:0] {
    reg_x0    = 3'd0,
    reg_y0    = 3'd1,
    reg_x1    = 3'd2,
    reg_y1    = 3'd3,
    reg_color = 3'd4,
    reg_cmd   = 3'd5
  } reg_addr_e;

  typedef enum logic [1:0] {
    idle,
    walk,
    done
  } draw_state_e;

endpackage

// File: rtl/gfx_params.svh
// video mode timing, colour width, coordinate width and framebuffer depth macros
`ifndef GFX_PARAMS_SVH
`define GFX_PARAMS_SVH

// bits per colour channel and per packed rgb pixel
`define COLOR_W 4
`define PIX_W (3 * `COLOR_W)

// coordinate widths
`define X_W 5
`define Y_W 4

// horizontal timing in pixels
`define H_ACTIVE 16
`define H_FP 2
`define H_SYNC 4
`define H_BP 2
`define H_TOTAL (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP)

// vertical timing in lines
`define V_ACTIVE 8
`define V_FP 1
`define V_SYNC 2
`define V_BP 1
`define V_TOTAL (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP)

// default stripe count and the matching bank depth
`define FB_NUM_S 2
`define FB_WORDS (`H_ACTIVE * `V_ACTIVE / `FB_NUM_S)

`endif

// File: rtl/gfx_striped_top.sv
// top level joining registers, drawer, striped framebuffer, timing and scanout
`timescale 1ns/1ns
`include "gfx_params.svh"

module gfx_striped_top
  import gfx_draw_pkg::*;
#(
  parameter int NUM_S = `FB_NUM_S
) (
  input  logic                pixel_clk,
  input  logic                rst_n,
  input  logic                reg_wr,
  input  reg_addr_e           reg_addr,
  input  logic [`PIX_W-1:0]   reg_wdata,
  output logic                busy,
  output logic [`COLOR_W-1:0] vga_red,
  output logic [`COLOR_W-1:0] vga_grn,
  output logic [`COLOR_W-1:0] vga_blu,
  output logic                vga_hsync,
  output logic                vga_vsync
);

  localparam int ADDR_W = $clog2(`FB_WORDS);

  // command registers to drawer
  logic                    start;
  shape_op_e               op;
  logic [`X_W-1:0]         x0;
  logic [`Y_W-1:0]         y0;
  logic [`X_W-1:0]         x1;
  logic [`Y_W-1:0]         y1;
  logic [`PIX_W-1:0]       color;

  // drawer write port
  logic                    wr_en;
  logic [`X_W-1:0]         wr_x;
  logic [`Y_W-1:0]         wr_y;
  logic [`PIX_W-1:0]       wr_color;
  logic                    wr_stall;

  // scanout read port and timing
  logic                    rd_en;
  logic [ADDR_W-1:0]       rd_addr;
  logic [NUM_S*`PIX_W-1:0] rd_data;
  logic [`X_W-1:0]         t_x;
  logic [`Y_W-1:0]         t_y;
  logic                    t_active;
  logic                    t_hsync;
  logic                    t_vsync;

  shape_regs i_shape_regs (
    .pixel_clk(pixel_clk), .rst_n(rst_n), .reg_wr(reg_wr), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .busy(busy), .start(start), .op(op),
    .x0(x0), .y0(y0), .x1(x1), .y1(y1), .color(color)
  );

  shape_drawer i_shape_drawer (
    .pixel_clk(pixel_clk), .rst_n(rst_n), .start(start), .op(op),
    .x0(x0), .y0(y0), .x1(x1), .y1(y1), .color(color), .wr_stall(wr_stall),
    .busy(busy), .wr_en(wr_en), .wr_x(wr_x), .wr_y(wr_y), .wr_color(wr_color)
  );

  stripe_fb #(.NUM_S(NUM_S)) i_stripe_fb (
    .pixel_clk(pixel_clk), .wr_en(wr_en), .wr_x(wr_x), .wr_y(wr_y),
    .wr_color(wr_color), .rd_en(rd_en), .rd_addr(rd_addr),
    .wr_stall(wr_stall), .rd_data(rd_data)
  );

  vga_timing i_vga_timing (
    .pixel_clk(pixel_clk), .rst_n(rst_n), .x(t_x), .y(t_y),
    .active(t_active), .hsync(t_hsync), .vsync(t_vsync)
  );

  fb_scanout #(.NUM_S(NUM_S)) i_fb_scanout (
    .pixel_clk(pixel_clk), .rst_n(rst_n), .x(t_x), .y(t_y), .active(t_active),
    .hsync(t_hsync), .vsync(t_vsync), .rd_data(rd_data), .rd_en(rd_en),
    .rd_addr(rd_addr), .vga_red(vga_red), .vga_grn(vga_grn), .vga_blu(vga_blu),
    .vga_hsync(vga_hsync), .vga_vsync(vga_vsync)
  );

endmodule

// File: rtl/shape_drawer.sv
// shape drawer FSM walking the command rectangle into single pixel writes
`timescale 1ns/1ns
`include "gfx_params.svh"

module shape_drawer
  import gfx_draw_pkg::*;
(
  input  logic              pixel_clk,
  input  logic              rst_n,
  input  logic              start,
  input  shape_op_e         op,
  input  logic [`X_W-1:0]   x0,
  input  logic [`Y_W-1:0]   y0,
  input  logic [`X_W-1:0]   x1,
  input  logic [`Y_W-1:0]   y1,
  input  logic [`PIX_W-1:0] color,
  input  logic              wr_stall,
  output logic              busy,
  output logic              wr_en,
  output logic [`X_W-1:0]   wr_x,
  output logic [`Y_W-1:0]   wr_y,
  output logic [`PIX_W-1:0] wr_color
);

  draw_state_e       state;
  logic [`X_W-1:0]   ld_x0;
  logic [`Y_W-1:0]   ld_y0;
  logic [`X_W-1:0]   ld_x1;
  logic [`Y_W-1:0]   ld_y1;
  logic              empty;
  logic [`X_W-1:0]   bx0;
  logic [`X_W-1:0]   bx1;
  logic [`Y_W-1:0]   by0;
  logic [`Y_W-1:0]   by1;
  logic [`X_W-1:0]   cx;
  logic [`Y_W-1:0]   cy;
  logic              frame_q;
  logic [`PIX_W-1:0] color_q;
  logic              last_pix;
  logic              skip_row;

  // clear always covers the whole screen
  assign ld_x0 = (op == op_clear) ? '0 : x0;
  assign ld_y0 = (op == op_clear) ? '0 : y0;
  assign ld_x1 = (op == op_clear) ? `X_W'(`H_ACTIVE - 1) : x1;
  assign ld_y1 = (op == op_clear) ? `Y_W'(`V_ACTIVE - 1) : y1;
  assign empty = (ld_x1 < ld_x0) || (ld_y1 < ld_y0);

  assign last_pix = (cx == bx1) && (cy == by1);
  // frame interior rows jump from the left edge straight to the right edge
  assign skip_row = frame_q && (cy != by0) && (cy != by1) && (cx == bx0);

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (start) begin
            state <= empty ? done : walk;
          end
        end
        walk: begin
          if (!wr_stall && last_pix) begin
            state <= idle;
          end
        end
        // empty rectangle, one busy cycle only
        done:    state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (state == idle && start) begin
      bx0     <= ld_x0;
      bx1     <= ld_x1;
      by0     <= ld_y0;
      by1     <= ld_y1;
      cx      <= ld_x0;
      cy      <= ld_y0;
      frame_q <= (op == op_frame);
      color_q <= color;
    end else if (state == walk && !wr_stall) begin
      if (cx == bx1) begin
        cx <= bx0;
        cy <= cy + 1'b1;
      end else if (skip_row) begin
        cx <= bx1;
      end else begin
        cx <= cx + 1'b1;
      end
    end
  end

  assign busy     = (state != idle);
  assign wr_en    = (state == walk);
  assign wr_x     = cx;
  assign wr_y     = cy;
  assign wr_color = color_q;

endmodule

// File: rtl/shape_regs.sv
// shape command register block with start pulse generation
`timescale 1ns/1ns
`include "gfx_params.svh"

module shape_regs
  import gfx_draw_pkg::*;
(
  input  logic              pixel_clk,
  input  logic              rst_n,
  input  logic              reg_wr,
  input  reg_addr_e         reg_addr,
  input  logic [`PIX_W-1:0] reg_wdata,
  input  logic              busy,
  output logic              start,
  output shape_op_e         op,
  output logic [`X_W-1:0]   x0,
  output logic [`Y_W-1:0]   y0,
  output logic [`X_W-1:0]   x1,
  output logic [`Y_W-1:0]   y1,
  output logic [`PIX_W-1:0] color
);

  logic cmd_accept;

  // start is still in flight the cycle before busy rises, so block that cycle too
  assign cmd_accept = reg_wr && (reg_addr == reg_cmd) && !busy && !start;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      start <= 1'b0;
      op    <= op_clear;
      x0    <= '0;
      y0    <= '0;
      x1    <= '0;
      y1    <= '0;
      color <= '0;
    end else begin
      start <= cmd_accept;
      if (reg_wr) begin
        case (reg_addr)
          reg_x0:    x0 <= reg_wdata[`X_W-1:0];
          reg_y0:    y0 <= reg_wdata[`Y_W-1:0];
          reg_x1:    x1 <= reg_wdata[`X_W-1:0];
          reg_y1:    y1 <= reg_wdata[`Y_W-1:0];
          reg_color: color <= reg_wdata;
          reg_cmd: begin
            if (cmd_accept) begin
              op <= shape_op_e'(reg_wdata[1:0]);
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// File: rtl/stripe_fb.sv
// striped framebuffer of NUM_S single port banks with read priority and write stall
`timescale 1ns/1ns
`include "gfx_params.svh"

module stripe_fb #(
  parameter int NUM_S = `FB_NUM_S
) (
  input  logic                        pixel_clk,
  input  logic                        wr_en,
  input  logic [`X_W-1:0]             wr_x,
  input  logic [`Y_W-1:0]             wr_y,
  input  logic [`PIX_W-1:0]           wr_color,
  input  logic                        rd_en,
  input  logic [$clog2(`FB_WORDS)-1:0] rd_addr,
  output logic                        wr_stall,
  output logic [NUM_S*`PIX_W-1:0]     rd_data
);

  localparam int ADDR_W    = $clog2(`FB_WORDS);
  localparam int ROW_WORDS = `H_ACTIVE / NUM_S;

  logic [ADDR_W-1:0] wr_word;
  logic              wr_go;

  // word index of the pixel within its bank
  assign wr_word = ADDR_W'(32'(wr_y) * ROW_WORDS + 32'(wr_x) / NUM_S);

  // a group read takes every bank this cycle
  assign wr_stall = wr_en && rd_en;
  assign wr_go    = wr_en && !rd_en;

  for (genvar b = 0; b < NUM_S; b++) begin : g_bank
    logic [`PIX_W-1:0] mem [`FB_WORDS];
    logic              sel;

    assign sel = (32'(wr_x) % NUM_S) == b;

    // one access per bank and cycle
    always_ff @(posedge pixel_clk) begin
      if (rd_en) begin
        rd_data[b*`PIX_W +: `PIX_W] <= mem[rd_addr];
      end else if (wr_go && sel) begin
        mem[wr_word] <= wr_color;
      end
    end
  end

endmodule

// File: rtl/vga_pkg.sv
// scan phase enum shared by the horizontal and vertical timing counters
package vga_pkg;

  // phases in the order they occur within a line or a frame
  typedef enum logic [1:0] {
    ph_active = 2'd0,
    ph_front  = 2'd1,
    ph_sync   = 2'd2,
    ph_back   = 2'd3
  } scan_phase_e;

endpackage

// File: rtl/vga_timing.sv
// horizontal and vertical scan phase FSMs with syncs, active flag and position
`timescale 1ns/1ns
`include "gfx_params.svh"

module vga_timing
  import vga_pkg::*;
(
  input  logic            pixel_clk,
  input  logic            rst_n,
  output logic [`X_W-1:0] x,
  output logic [`Y_W-1:0] y,
  output logic            active,
  output logic            hsync,
  output logic            vsync
);

  scan_phase_e     h_ph;
  scan_phase_e     v_ph;
  logic [`X_W-1:0] h_cnt;
  logic [`Y_W-1:0] v_cnt;
  logic            h_last;
  logic            v_last;

  function automatic scan_phase_e next_phase(input scan_phase_e p);
    case (p)
      ph_active: return ph_front;
      ph_front:  return ph_sync;
      ph_sync:   return ph_back;
      default:   return ph_active;
    endcase
  endfunction

  // phase lengths in pixels
  function automatic int h_len(input scan_phase_e p);
    case (p)
      ph_active: return `H_ACTIVE;
      ph_front:  return `H_FP;
      ph_sync:   return `H_SYNC;
      default:   return `H_BP;
    endcase
  endfunction

  // phase lengths in lines
  function automatic int v_len(input scan_phase_e p);
    case (p)
      ph_active: return `V_ACTIVE;
      ph_front:  return `V_FP;
      ph_sync:   return `V_SYNC;
      default:   return `V_BP;
    endcase
  endfunction

  assign h_last = (32'(h_cnt) == h_len(h_ph) - 1);
  assign v_last = (32'(v_cnt) == v_len(v_ph) - 1);

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      h_ph  <= ph_active;
      h_cnt <= '0;
      v_ph  <= ph_active;
      v_cnt <= '0;
    end else begin
      if (h_last) begin
        h_ph  <= next_phase(h_ph);
        h_cnt <= '0;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
      // vertical state moves once per line, at the end of the back porch
      if (h_last && h_ph == ph_back) begin
        if (v_last) begin
          v_ph  <= next_phase(v_ph);
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 1'b1;
        end
      end
    end
  end

  // position is meaningful only while active is high
  assign x      = h_cnt;
  assign y      = v_cnt;
  assign active = (h_ph == ph_active) && (v_ph == ph_active);
  assign hsync  = (h_ph != ph_sync);
  assign vsync  = (v_ph != ph_sync);

endmodule

// File: tb/gfx_striped_chk.sv
// concurrent assertions on reset values, sync timing, blanking and busy behaviour
`timescale 1ns/1ns
`include "gfx_params.svh"

module gfx_striped_chk
  import gfx_draw_pkg::*;
(
  input logic                pixel_clk,
  input logic                rst_n,
  input logic                reg_wr,
  input reg_addr_e           reg_addr,
  input logic                start,
  input logic                busy,
  input logic [`COLOR_W-1:0] vga_red,
  input logic [`COLOR_W-1:0] vga_grn,
  input logic [`COLOR_W-1:0] vga_blu,
  input logic                vga_hsync,
  input logic                vga_vsync
);

  logic cmd_wr;
  logic rgb_zero;

  assign cmd_wr   = reg_wr && (reg_addr == reg_cmd);
  assign rgb_zero = (vga_red == '0) && (vga_grn == '0) && (vga_blu == '0);

  // outputs idle right after every reset cycle
  a_reset_idle: assert property (@(posedge pixel_clk)
    !rst_n |=> (vga_hsync && vga_vsync && rgb_zero && !busy))
    else $error("outputs not idle after reset");

  // ph_sync lasts H_SYNC pixels, the other phases fill the rest of the line
  a_hsync_low: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    $fell(vga_hsync) |-> ##(`H_SYNC) $rose(vga_hsync))
    else $error("hsync low run has the wrong length");

  a_hsync_high: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    $rose(vga_hsync) |-> ##(`H_TOTAL - `H_SYNC) $fell(vga_hsync))
    else $error("hsync period is not one line");

  // vertical ph_sync spans two whole lines
  a_vsync_low: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    $fell(vga_vsync) |-> ##(`V_SYNC * `H_TOTAL) $rose(vga_vsync))
    else $error("vsync low run has the wrong length");

  a_vsync_high: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    $rose(vga_vsync) |-> ##((`V_TOTAL - `V_SYNC) * `H_TOTAL) $fell(vga_vsync))
    else $error("vsync period is not one frame");

  a_blank: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (!vga_hsync || !vga_vsync) |-> rgb_zero)
    else $error("colour output during a sync pulse");

  a_busy_rise: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (cmd_wr && !busy && !start) |-> ##2 $rose(busy))
    else $error("busy did not rise two cycles after the command write");

  // a dropped command never produces a start
  a_cmd_ignored: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (cmd_wr && (busy || start)) |=> !start)
    else $error("command write while busy was accepted");

  a_busy_src: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    $rose(busy) |-> $past(start))
    else $error("busy rose without a start pulse");

endmodule

// File: tb/gfx_striped_tb.sv
// testbench with register stimulus, reference image model and frame comparison
`timescale 1ns/1ns
`include "gfx_params.svh"

module gfx_striped_tb
  import gfx_draw_pkg::*;
();

  localparam int PW         = `PIX_W;
  localparam int MAX_CYCLES = 20 * `H_TOTAL * `V_TOTAL;
  localparam int FIRST_LINE = `V_SYNC + `V_BP;

  logic                pixel_clk;
  logic                rst_n;
  logic                reg_wr;
  reg_addr_e           reg_addr;
  logic [`PIX_W-1:0]   reg_wdata;
  logic                busy;
  logic [`COLOR_W-1:0] vga_red;
  logic [`COLOR_W-1:0] vga_grn;
  logic [`COLOR_W-1:0] vga_blu;
  logic                vga_hsync;
  logic                vga_vsync;

  // expected framebuffer contents, row major
  logic [`PIX_W-1:0]   ref_img [`H_ACTIVE * `V_ACTIVE];
  int                  seed = 56;
  int                  cycle_cnt = 0;

  gfx_striped_top i_gfx_striped_top (
    .pixel_clk(pixel_clk), .rst_n(rst_n), .reg_wr(reg_wr), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .busy(busy), .vga_red(vga_red), .vga_grn(vga_grn),
    .vga_blu(vga_blu), .vga_hsync(vga_hsync), .vga_vsync(vga_vsync)
  );

  bind gfx_striped_top gfx_striped_chk i_gfx_striped_chk (
    .pixel_clk(pixel_clk), .rst_n(rst_n), .reg_wr(reg_wr), .reg_addr(reg_addr),
    .start(start), .busy(busy), .vga_red(vga_red), .vga_grn(vga_grn),
    .vga_blu(vga_blu), .vga_hsync(vga_hsync), .vga_vsync(vga_vsync)
  );

  initial pixel_clk = 1'b0;
  always #10 pixel_clk = ~pixel_clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  // 20 frames is well above six commands of two frames each
  always @(posedge pixel_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      fail_run("Timeout, the run did not finish within 20 frames");
    end
  end

  // inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge pixel_clk);
    #2;
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [`PIX_W-1:0] data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    next_cycle();
    reg_wr    = 1'b0;
  endtask

  function automatic int rand_below(input int n);
    return int'({$random(seed)} % 32'(n));
  endfunction

  // shape rules applied to the expected image
  function automatic void draw_ref(input shape_op_e op, input int x0, input int y0,
                                   input int x1, input int y1,
                                   input logic [`PIX_W-1:0] color);
    int lx0;
    int ly0;
    int lx1;
    int ly1;
    lx0 = x0;
    ly0 = y0;
    lx1 = x1;
    ly1 = y1;
    if (op == op_clear) begin
      lx0 = 0;
      ly0 = 0;
      lx1 = `H_ACTIVE - 1;
      ly1 = `V_ACTIVE - 1;
    end
    // swapped corners leave the loops empty
    for (int py = ly0; py <= ly1; py++) begin
      for (int px = lx0; px <= lx1; px++) begin
        if (op != op_frame || px == lx0 || px == lx1 || py == ly0 || py == ly1) begin
          ref_img[py * `H_ACTIVE + px] = color;
        end
      end
    end
  endfunction

  task automatic load_shape(input shape_op_e op, input int x0, input int y0,
                            input int x1, input int y1, input logic [`PIX_W-1:0] color);
    write_reg(reg_x0, PW'(x0));
    write_reg(reg_y0, PW'(y0));
    write_reg(reg_x1, PW'(x1));
    write_reg(reg_y1, PW'(y1));
    write_reg(reg_color, color);
    write_reg(reg_cmd, PW'(op));
    draw_ref(op, x0, y0, x1, y1, color);
  endtask

  task automatic wait_idle();
    while (!busy) begin
      next_cycle();
    end
    while (busy) begin
      next_cycle();
    end
  endtask

  task automatic check_channel(input string name, input logic [`COLOR_W-1:0] got,
                               input logic [`COLOR_W-1:0] exp_val, input int px,
                               input int scan_line);
    assert (got === exp_val) else
      fail_run($sformatf("Mismatch %s at line %0d pixel %0d: got %h expected %h",
                         name, scan_line, px, got, exp_val));
  endtask

  // one whole frame, counted from the start of the vsync pulse
  task automatic check_frame();
    logic [`PIX_W-1:0] exp_pix;
    @(negedge vga_vsync);
    for (int scan_line = 0; scan_line < `V_TOTAL; scan_line++) begin
      for (int px = 0; px < `H_TOTAL; px++) begin
        @(negedge pixel_clk);
        exp_pix = '0;
        if (px < `H_ACTIVE && scan_line >= FIRST_LINE &&
            scan_line < FIRST_LINE + `V_ACTIVE) begin
          exp_pix = ref_img[(scan_line - FIRST_LINE) * `H_ACTIVE + px];
        end
        check_channel("vga_red", vga_red, exp_pix[3*`COLOR_W-1:2*`COLOR_W], px, scan_line);
        check_channel("vga_grn", vga_grn, exp_pix[2*`COLOR_W-1:`COLOR_W], px, scan_line);
        check_channel("vga_blu", vga_blu, exp_pix[`COLOR_W-1:0], px, scan_line);
      end
    end
  endtask

  initial begin
    int ax;
    int bx;
    int ay;
    int by;
    logic [`PIX_W-1:0] col;
    rst_n     = 1'b0;
    reg_wr    = 1'b0;
    reg_addr  = reg_x0;
    reg_wdata = '0;
    repeat (5) @(posedge pixel_clk);
    #2;
    rst_n = 1'b1;

    // whole screen clear
    col = PW'($random(seed));
    load_shape(op_clear, 0, 0, 0, 0, col);
    wait_idle();
    check_frame();
    next_cycle();

    // solid rectangle drawn during scanout
    ax  = rand_below(`H_ACTIVE);
    bx  = rand_below(`H_ACTIVE);
    ay  = rand_below(`V_ACTIVE);
    by  = rand_below(`V_ACTIVE);
    col = PW'($random(seed));
    load_shape(op_fill, (ax < bx) ? ax : bx, (ay < by) ? ay : by,
               (ax < bx) ? bx : ax, (ay < by) ? by : ay, col);
    wait_idle();
    check_frame();
    next_cycle();

    // outline around at least one interior pixel
    ax  = rand_below(`H_ACTIVE - 2);
    bx  = ax + 2 + rand_below(`H_ACTIVE - 2 - ax);
    ay  = rand_below(`V_ACTIVE - 2);
    by  = ay + 2 + rand_below(`V_ACTIVE - 2 - ay);
    col = PW'($random(seed));
    load_shape(op_frame, ax, ay, bx, by, col);
    wait_idle();
    check_frame();
    next_cycle();

    // corners swapped so nothing is drawn
    ax  = 1 + rand_below(`H_ACTIVE - 1);
    bx  = rand_below(ax);
    ay  = 1 + rand_below(`V_ACTIVE - 1);
    by  = rand_below(ay);
    col = PW'($random(seed));
    load_shape(op_fill, ax, ay, bx, by, col);
    wait_idle();
    check_frame();
    next_cycle();

    // second command while busy must be dropped
    col = PW'($random(seed));
    load_shape(op_fill, 2, 1, 13, 6, col);
    while (!busy) begin
      next_cycle();
    end
    write_reg(reg_color, ~col);
    write_reg(reg_cmd, PW'(op_clear));
    wait_idle();
    check_frame();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
